// ==== Makefile ====
# Verilator build and run of the USB receive testbench

VERILATOR ?= verilator
TOP       ?= usbRxTb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
LOG       ?= sim.log
PASS_TEXT ?= Testbench passed
VFLAGS    ?= -j 0

SRCS    := $(wildcard design/*.sv test/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
design/usbRxPkg.sv
design/usbSerialFrontend.sv
design/eopResetDetect.sv
design/bitTimer.sv
design/nrziUnstuff.sv
design/packetReceiver.sv
design/usbRxTop.sv
test/usbRxTb.sv

// ==== design/bitTimer.sv ====
module bitTimer #(
    parameter int unsigned BitCycles = usbRxPkg::DefBitCycles
) (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  usbRxPkg::lineState_t lineState_i,
    output logic                 sampleStrobe_o
);
    import usbRxPkg::*;

    localparam int unsigned       PhaseW    = (BitCycles > 1) ? $clog2(BitCycles) : 1;
    localparam logic [PhaseW-1:0] LastPhase = PhaseW'(BitCycles - 1);
    localparam logic [PhaseW-1:0] MidPhase  = PhaseW'(BitCycles / 2);

    lineState_t        prevState;
    logic              lineChanged;
    logic              tracking;    // Set once the first edge has been seen
    logic [PhaseW-1:0] phaseReg;
    logic [PhaseW-1:0] phase;

    assign lineChanged = (lineState_i != prevState);

    // The clock of a transition is phase 0 of the new bit
    assign phase = lineChanged ? '0 : phaseReg;

    assign sampleStrobe_o = tracking && (phase == MidPhase);

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            prevState <= LsJ;
            tracking  <= 1'b0;
            phaseReg  <= '0;
        end else begin
            prevState <= lineState_i;
            if (lineChanged) begin
                tracking <= 1'b1;
            end
            if (tracking || lineChanged) begin
                phaseReg <= (phase == LastPhase) ? '0 : phase + 1'b1;   // Free run between edges
            end
        end
    end

    strobeSpacing: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        sampleStrobe_o |=> !sampleStrobe_o
    ) else $error("Sample strobes in back to back cycles");

endmodule

// ==== design/eopResetDetect.sv ====
module eopResetDetect #(
    parameter int unsigned EopMinCycles = usbRxPkg::DefEopMinCycles,
    parameter int unsigned ResetCycles  = usbRxPkg::DefResetCycles
) (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  usbRxPkg::lineState_t lineState_i,
    input  logic                 ackUsbRst_i,
    output logic                 eopPulse_o,
    output logic                 usbReset_o
);
    import usbRxPkg::*;

    localparam int unsigned       CountW   = $clog2(ResetCycles + 1);
    localparam logic [CountW-1:0] EopMin   = CountW'(EopMinCycles);
    localparam logic [CountW-1:0] ResetLen = CountW'(ResetCycles);

    logic [CountW-1:0] se0Count;   // Length of the current SE0 run, saturating
    logic              isSe0;

    assign isSe0 = (lineState_i == LsSe0);

    // End of packet shows on the first J after a long enough SE0
    assign eopPulse_o = (lineState_i == LsJ) && (se0Count >= EopMin);

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            se0Count   <= '0;
            usbReset_o <= 1'b0;
        end else begin
            if (!isSe0) begin
                se0Count <= '0;
            end else if (se0Count != ResetLen) begin
                se0Count <= se0Count + 1'b1;
            end

            // Sticky until acknowledged, ack has priority
            if (ackUsbRst_i) begin
                usbReset_o <= 1'b0;
            end else if (isSe0 && (se0Count == ResetLen - 1'b1)) begin
                usbReset_o <= 1'b1;
            end
        end
    end

    eopSingleCycle: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        eopPulse_o |=> !eopPulse_o
    ) else $error("EOP pulse longer than one cycle");

endmodule

// ==== design/nrziUnstuff.sv ====
module nrziUnstuff (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  usbRxPkg::lineState_t lineState_i,
    input  logic                 sampleStrobe_i,
    output logic                 bitValid_o,
    output logic                 bitData_o,
    output logic                 stuffError_o
);
    import usbRxPkg::*;

    localparam logic [2:0] MaxOnes = 3'd6;

    logic       prevJ;       // Level of the previous sample
    logic       curJ;
    logic       decoded;
    logic       isSe0;
    logic [2:0] onesCount;
    logic       lineIdle;    // Idle J between packets, ones are not data

    assign isSe0   = (lineState_i == LsSe0);
    assign curJ    = (lineState_i == LsJ);
    assign decoded = (curJ == prevJ);   // No transition decodes to 1

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            prevJ        <= 1'b1;
            onesCount    <= '0;
            lineIdle     <= 1'b1;
            bitValid_o   <= 1'b0;
            stuffError_o <= 1'b0;
        end else begin
            bitValid_o   <= 1'b0;
            stuffError_o <= 1'b0;
            if (sampleStrobe_i) begin
                if (isSe0) begin
                    // EOP or bus reset, restart from idle J
                    prevJ     <= 1'b1;
                    onesCount <= '0;
                    lineIdle  <= 1'b1;
                end else begin
                    prevJ <= curJ;
                    if (onesCount == MaxOnes) begin
                        // Stuffed position, must be a zero and is dropped
                        onesCount    <= '0;
                        stuffError_o <= decoded;
                    end else if (!(lineIdle && decoded)) begin
                        bitValid_o <= 1'b1;
                        lineIdle   <= 1'b0;   // First K starts the packet
                        onesCount  <= decoded ? onesCount + 1'b1 : 3'd0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (sampleStrobe_i) begin
            bitData_o <= decoded;
        end
    end

endmodule

// ==== design/packetReceiver.sv ====
module packetReceiver (
    input  logic       clk48_i,
    input  logic       rst_i,
    input  logic       bitValid_i,
    input  logic       bitData_i,
    input  logic       stuffError_i,
    input  logic       eopPulse_i,
    output logic [7:0] rxByte_o,
    output logic       rxValid_o,
    output logic       rxEnd_o,
    output logic       rxError_o
);
    import usbRxPkg::*;

    rxState_t   state;
    logic [7:0] shiftReg;    // SYNC search window, then byte assembly
    logic [7:0] shiftNext;
    logic [2:0] bitCount;
    logic       endError;
    logic       waitEop;     // Bits ignored after a stuff error until EOP

    assign shiftNext = {bitData_i, shiftReg[7:1]};   // LSB first

    // DONE lasts exactly one cycle
    assign rxEnd_o   = (state == RxDone);
    assign rxError_o = rxEnd_o & endError;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state     <= RxIdle;
            bitCount  <= '0;
            endError  <= 1'b0;
            waitEop   <= 1'b0;
            rxValid_o <= 1'b0;
        end else begin
            rxValid_o <= 1'b0;
            if (eopPulse_i) begin
                waitEop <= 1'b0;
            end

            case (state)
                RxIdle: begin
                    if (bitValid_i && !waitEop) begin
                        state <= RxSync;
                    end
                end
                RxSync, RxData: begin
                    if (stuffError_i) begin
                        state    <= RxDone;
                        endError <= 1'b1;
                        waitEop  <= !eopPulse_i;
                    end else if (eopPulse_i) begin
                        state    <= RxDone;
                        endError <= (state == RxSync) || (bitCount != 3'd0);   // Partial byte
                    end else if (bitValid_i) begin
                        if (state == RxSync) begin
                            if (shiftNext == SyncPattern) begin
                                state    <= RxData;
                                bitCount <= '0;
                            end
                        end else begin
                            bitCount <= bitCount + 1'b1;
                            if (bitCount == 3'd7) begin
                                rxValid_o <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= RxIdle;
            endcase
        end
    end

    always_ff @(posedge clk48_i) begin
        if (bitValid_i) begin
            // Ones padding keeps SYNC from matching before eight real bits
            shiftReg <= (state == RxIdle) ? {bitData_i, 7'h7f} : shiftNext;
        end
        if (bitValid_i && (state == RxData) && (bitCount == 3'd7)) begin
            rxByte_o <= shiftNext;
        end
    end

    validOnlyInData: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        rxValid_o |-> (state == RxData) && $past(bitValid_i)
    ) else $error("Byte strobe outside of packet data");

endmodule

// ==== design/usbRxPkg.sv ====
package usbRxPkg;

    // Bus state as {D+, D-} after the synchronizer, full-speed polarity
    typedef enum logic [1:0] {
        LsSe0 = 2'b00,
        LsK   = 2'b01,
        LsJ   = 2'b10,   // Idle level for a full-speed device
        LsSe1 = 2'b11
    } lineState_t;

    // Packet receiver states
    typedef enum logic [1:0] {
        RxIdle = 2'b00,
        RxSync = 2'b01,
        RxData = 2'b10,
        RxDone = 2'b11
    } rxState_t;

    localparam int unsigned DefSyncStages   = 2;
    localparam int unsigned DefBitCycles    = 4;    // 48 MHz / 12 Mbit/s
    localparam int unsigned DefResetCycles  = 120;  // 2.5 us of SE0
    localparam int unsigned DefEopMinCycles = 4;

    // KJKJKJKK decodes to seven zeros and a one, received LSB first
    localparam logic [7:0] SyncPattern = 8'h80;

endpackage

// ==== design/usbRxTop.sv ====
module usbRxTop #(
    parameter int unsigned SyncStages   = usbRxPkg::DefSyncStages,
    parameter int unsigned BitCycles    = usbRxPkg::DefBitCycles,
    parameter int unsigned EopMinCycles = usbRxPkg::DefEopMinCycles,
    parameter int unsigned ResetCycles  = usbRxPkg::DefResetCycles
) (
    input  logic       clk48_i,
    input  logic       rst_i,
    input  logic       pinP_i,
    input  logic       pinN_i,
    input  logic       dataOutEn_i,
    input  logic       dataOutP_i,
    input  logic       dataOutN_i,
    input  logic       ackUsbRst_i,
    output logic       pinP_o,
    output logic       pinN_o,
    output logic       pinOe_o,
    output logic       isValidDP_o,
    output logic       usbReset_o,
    output logic [7:0] rxByte_o,
    output logic       rxValid_o,
    output logic       rxEnd_o,
    output logic       rxError_o
);
    import usbRxPkg::*;

    lineState_t lineState;
    logic       sampleStrobe;
    logic       bitValid;
    logic       bitData;
    logic       stuffError;
    logic       eopPulse;

    usbSerialFrontend #(
        .SyncStages (SyncStages)
    ) frontend (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .pinP_i      (pinP_i),
        .pinN_i      (pinN_i),
        .dataOutEn_i (dataOutEn_i),
        .dataOutP_i  (dataOutP_i),
        .dataOutN_i  (dataOutN_i),
        .pinP_o      (pinP_o),
        .pinN_o      (pinN_o),
        .pinOe_o     (pinOe_o),
        .lineState_o (lineState),
        .isValidDP_o (isValidDP_o)
    );

    eopResetDetect #(
        .EopMinCycles (EopMinCycles),
        .ResetCycles  (ResetCycles)
    ) eopDetect (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .lineState_i (lineState),
        .ackUsbRst_i (ackUsbRst_i),
        .eopPulse_o  (eopPulse),
        .usbReset_o  (usbReset_o)
    );

    bitTimer #(
        .BitCycles (BitCycles)
    ) timer (
        .clk48_i        (clk48_i),
        .rst_i          (rst_i),
        .lineState_i    (lineState),
        .sampleStrobe_o (sampleStrobe)
    );

    nrziUnstuff decoder (
        .clk48_i        (clk48_i),
        .rst_i          (rst_i),
        .lineState_i    (lineState),
        .sampleStrobe_i (sampleStrobe),
        .bitValid_o     (bitValid),
        .bitData_o      (bitData),
        .stuffError_o   (stuffError)
    );

    packetReceiver receiver (
        .clk48_i      (clk48_i),
        .rst_i        (rst_i),
        .bitValid_i   (bitValid),
        .bitData_i    (bitData),
        .stuffError_i (stuffError),
        .eopPulse_i   (eopPulse),
        .rxByte_o     (rxByte_o),
        .rxValid_o    (rxValid_o),
        .rxEnd_o      (rxEnd_o),
        .rxError_o    (rxError_o)
    );

endmodule

// ==== design/usbSerialFrontend.sv ====
module usbSerialFrontend #(
    parameter int unsigned SyncStages = usbRxPkg::DefSyncStages
) (
    input  logic                 clk48_i,
    input  logic                 rst_i,
    input  logic                 pinP_i,
    input  logic                 pinN_i,
    input  logic                 dataOutEn_i,
    input  logic                 dataOutP_i,
    input  logic                 dataOutN_i,
    output logic                 pinP_o,
    output logic                 pinN_o,
    output logic                 pinOe_o,
    output usbRxPkg::lineState_t lineState_o,
    output logic                 isValidDP_o
);
    import usbRxPkg::*;

    logic [SyncStages-1:0] syncP;
    logic [SyncStages-1:0] syncN;
    logic [1:0]            outEnHist;   // Output enable of the last two clocks
    logic                  dataInP;
    logic                  dataInN;

    // Transmit side goes straight to the pads
    assign pinP_o  = dataOutP_i;
    assign pinN_o  = dataOutN_i;
    assign pinOe_o = dataOutEn_i;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            syncP     <= '1;   // Bus idles at J
            syncN     <= '0;
            outEnHist <= '0;
            dataInP   <= 1'b1;
            dataInN   <= 1'b0;
        end else begin
            // Shift in at bit 0, the oldest sample leaves at the top
            syncP     <= SyncStages'({syncP, pinP_i});
            syncN     <= SyncStages'({syncN, pinN_i});
            outEnHist <= {outEnHist[0], dataOutEn_i};

            if (outEnHist[1]) begin
                // Our own transmission echoes on the pins, hold idle J
                dataInP <= 1'b1;
                dataInN <= 1'b0;
            end else begin
                dataInP <= syncP[SyncStages-1];
                dataInN <= syncN[SyncStages-1];
            end
        end
    end

    assign lineState_o = lineState_t'({dataInP, dataInN});
    assign isValidDP_o = dataInP ^ dataInN;   // Differential only when the lines differ

    // While we drive the bus the receive path must read J three clocks later
    rxMaskedWhileTx: assert property (
        @(posedge clk48_i) disable iff (rst_i)
        pinOe_o |-> ##3 (lineState_o == LsJ)
    ) else $error("Receive line not masked during transmit");

endmodule

// ==== test/usbRxTb.sv ====
module usbRxTb;

    localparam int          BitClocks      = 4;
    localparam int          EopClocks      = 8;
    localparam int          DriveDelay     = 1;
    localparam int          NumRandom      = 24;
    localparam int          NumStuffed     = 8;
    localparam int          NumJitter      = 12;
    localparam int          NumViolations  = 6;
    localparam int          NumPackets     = NumRandom + NumStuffed + NumJitter + NumViolations + 1;
    localparam int          MaxPacketBits  = 100;   // SYNC, 8 bytes, stuffing, injection, EOP, gap
    localparam int          WatchdogCycles = NumPackets * MaxPacketBits * BitClocks + 1000;
    localparam logic [31:0] Seed           = 32'h97f7_e3fb;

    logic       clk48_i;
    logic       rst_i;
    logic       pinP_i;
    logic       pinN_i;
    logic       dataOutEn_i;
    logic       dataOutP_i;
    logic       dataOutN_i;
    logic       ackUsbRst_i;
    logic       pinP_o;
    logic       pinN_o;
    logic       pinOe_o;
    logic       isValidDP_o;
    logic       usbReset_o;
    logic [7:0] rxByte_o;
    logic       rxValid_o;
    logic       rxEnd_o;
    logic       rxError_o;

    logic [31:0] lfsr = Seed;
    logic [7:0]  pktData[$];
    bit          lineBits[$];        // Stuffed bit stream of the packet being built
    int          onesRun;
    logic [7:0]  expBytes[$];
    int          expCounts[$];
    bit          expErrors[$];
    int          pktByteCount = 0;
    int          endsSeen = 0;
    int          packetsSent = 0;
    bit          busResetAllowed = 1'b0;
    bit          txActive = 1'b0;
    logic [2:0]  pinHistP = 3'b111;  // Pin levels of the last three clocks, newest at bit 0
    logic [2:0]  pinHistN = 3'b000;

    usbRxTop #(.ResetCycles(40)) DUT (.*);

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsrStep();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic logic [31:0] pickBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsrStep()};
        end
        return value;
    endfunction

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic holdLine(input logic p, input logic n, input int cycles);
        pinP_i = p;
        pinN_i = n;
        repeat (cycles) @(posedge clk48_i);
        #DriveDelay;
    endtask

    task automatic appendStuffed(input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            lineBits.push_back(value[i]);   // LSB first
            onesRun = value[i] ? onesRun + 1 : 0;
            if (onesRun == 6) begin
                lineBits.push_back(1'b0);
                onesRun = 0;
            end
        end
    endtask

    task automatic sendPacket(input bit heavyOnes, input bit useJitter, input bit injectError);
        int   nBytes;
        int   injectAt;
        int   cycles;
        logic level;
        logic newLevel;
        bit   jitterInRun;
        nBytes   = 1 + int'(pickBits(3));
        injectAt = injectError ? int'(pickBits(3)) % nBytes : nBytes;
        pktData.delete();
        lineBits.delete();
        onesRun = 0;
        for (int i = 0; i < nBytes; i++) begin
            pktData.push_back((heavyOnes && lfsrStep()) ? 8'hff : 8'(pickBits(8)));
            if (i < injectAt) begin
                expBytes.push_back(pktData[i]);   // Nothing after the violation arrives
            end
        end
        expCounts.push_back(injectAt);
        expErrors.push_back(injectError);
        packetsSent++;

        appendStuffed(8'h80);   // SYNC
        for (int i = 0; i < nBytes; i++) begin
            if (i == injectAt) begin
                repeat (7) lineBits.push_back(1'b1);
            end
            appendStuffed(pktData[i]);
        end

        level       = 1'b1;
        jitterInRun = 1'b0;
        foreach (lineBits[i]) begin
            newLevel = lineBits[i] ? level : !level;   // NRZI where a zero toggles the line
            if (newLevel != level) begin
                jitterInRun = 1'b0;
            end
            level  = newLevel;
            cycles = BitClocks;
            // One short or long bit at most between two transitions
            if (useJitter && !jitterInRun && pickBits(2) == 0) begin
                cycles      = lfsrStep() ? 3 : 5;
                jitterInRun = 1'b1;
            end
            holdLine(level, !level, cycles);
        end
        holdLine(1'b0, 1'b0, EopClocks);
        holdLine(1'b1, 1'b0, BitClocks * (4 + int'(pickBits(2))));
        wait (endsSeen == packetsSent);
        @(posedge clk48_i);
        #DriveDelay;
    endtask

    initial begin
        clk48_i = 1'b0;
        forever #4 clk48_i = ~clk48_i;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge clk48_i);
        reportFailure($sformatf("The run did not finish within %0d clocks", WatchdogCycles));
    end

    // Pins reach the receive path three clocks after they are sampled
    always @(posedge clk48_i) begin
        pinHistP <= {pinHistP[1:0], pinP_i};
        pinHistN <= {pinHistN[1:0], pinN_i};
    end

    always @(negedge clk48_i) begin
        if (rst_i == 1'b0) begin
            assert (pinP_o == dataOutP_i && pinN_o == dataOutN_i && pinOe_o == dataOutEn_i)
            else reportFailure($sformatf(
                "FAILED pinP_o/pinN_o/pinOe_o: got %h/%h/%h, expected %h/%h/%h",
                pinP_o, pinN_o, pinOe_o, dataOutP_i, dataOutN_i, dataOutEn_i));
            if (!txActive) begin
                assert (isValidDP_o == (pinHistP[2] ^ pinHistN[2]))
                else reportFailure($sformatf("FAILED isValidDP_o: got %h, expected %h",
                                             isValidDP_o, pinHistP[2] ^ pinHistN[2]));
            end
            assert (busResetAllowed || !usbReset_o)
            else reportFailure("usbReset_o was set without a bus reset on the line");
            assert (!(txActive && (rxValid_o || rxEnd_o)))
            else reportFailure("Receiver reported data while the device was transmitting");
            if (rxValid_o) begin
                assert (expBytes.size() > 0)
                else reportFailure("A byte arrived when none was expected");
                assert (rxByte_o == expBytes[0])
                else reportFailure($sformatf("FAILED rxByte_o: got %h, expected %h",
                                             rxByte_o, expBytes[0]));
                void'(expBytes.pop_front());
                pktByteCount++;
            end
            if (rxEnd_o) begin
                assert (expCounts.size() > 0)
                else reportFailure("A packet end arrived when no packet was sent");
                assert (rxError_o == expErrors[0])
                else reportFailure($sformatf("FAILED rxError_o: got %h, expected %h",
                                             rxError_o, expErrors[0]));
                assert (pktByteCount == expCounts[0])
                else reportFailure($sformatf("FAILED rxValid_o count: got %h, expected %h",
                                             pktByteCount, expCounts[0]));
                void'(expCounts.pop_front());
                void'(expErrors.pop_front());
                pktByteCount = 0;
                endsSeen++;
            end
        end
    end

    initial begin
        rst_i       = 1'b1;
        pinP_i      = 1'b1;   // Idle J
        pinN_i      = 1'b0;
        dataOutEn_i = 1'b0;
        dataOutP_i  = 1'b0;
        dataOutN_i  = 1'b0;
        ackUsbRst_i = 1'b0;
        repeat (10) @(posedge clk48_i);
        #DriveDelay;
        rst_i = 1'b0;
        holdLine(1'b1, 1'b0, 8);

        repeat (NumRandom) sendPacket(1'b0, 1'b0, 1'b0);
        repeat (NumStuffed) sendPacket(1'b1, 1'b0, 1'b0);    // Many 8'hFF bytes
        repeat (NumJitter) sendPacket(1'b0, 1'b1, 1'b0);     // Bits of 3 or 5 clocks
        repeat (NumViolations) sendPacket(1'b0, 1'b0, 1'b1);

        // Long SE0 for a bus reset, then the flag holds until acknowledged
        busResetAllowed = 1'b1;
        holdLine(1'b0, 1'b0, 48);
        holdLine(1'b1, 1'b0, 4);
        repeat (8 + int'(pickBits(4))) begin
            assert (usbReset_o == 1'b1)
            else reportFailure($sformatf("FAILED usbReset_o: got %h, expected %h",
                                         usbReset_o, 1'b1));
            @(posedge clk48_i);
            #DriveDelay;
        end
        ackUsbRst_i = 1'b1;
        @(posedge clk48_i);
        #DriveDelay;
        ackUsbRst_i = 1'b0;
        assert (usbReset_o == 1'b0)
        else reportFailure($sformatf("FAILED usbReset_o: got %h, expected %h", usbReset_o, 1'b0));
        busResetAllowed = 1'b0;

        // Device transmits while the pins carry random levels
        dataOutEn_i = 1'b1;
        txActive    = 1'b1;
        holdLine(1'b1, 1'b0, 4);
        repeat (64) begin
            dataOutP_i = lfsrStep();
            dataOutN_i = lfsrStep();
            holdLine(lfsrStep(), lfsrStep(), 1);
        end
        holdLine(1'b1, 1'b0, 6);   // Flush the synchronizer before the mask drops
        dataOutEn_i = 1'b0;
        holdLine(1'b1, 1'b0, 8);
        txActive = 1'b0;
        sendPacket(1'b0, 1'b0, 1'b0);

        assert (expBytes.size() == 0 && expCounts.size() == 0)
        else reportFailure("Some expected bytes or packet ends never arrived");
        $display("Testbench passed");
        $finish;
    end

endmodule
